//--- all.f
logic/mshr_pkg.sv
logic/miss_intake.sv
logic/mshr_table.sv
logic/fill_return.sv
logic/mshr_top.sv
bench/mshr_assert.sv
bench/mshr_tb.sv

//--- run.sh
#!/bin/sh
# Builds the MSHR testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert --timing -f all.f --top-module mshr_tb -o mshr_sim \
    && ./obj_dir/mshr_sim > sim.log 2>&1

cat sim.log 2>/dev/null
test -f sim.log && ! grep -q "sim failed" sim.log && grep -q "sim passed" sim.log \
    && echo "run.sh: PASS" \
    || { echo "run.sh: FAIL"; exit 1; }

//--- bench/mshr_tb.sv
module mshr_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import mshr_pkg::*;

    localparam int SEED      = 78111;
    localparam int TIMEOUT   = 10;
    localparam int POOL_SIZE = 12;

    logic        clk;
    logic        arst_n;
    logic        req_valid;
    phys_addr_t  req_addr;
    slot_mask_t  req_slot;
    logic        req_store;
    logic        fill;
    req_status_t status;
    logic        mshr_full;
    logic        fill_valid;
    fill_resp_t  fill_resp;

    fill_resp_t  model_q[$]; // Outstanding lines in fill order.
    line_addr_t  pool[POOL_SIZE];

    mshr_top dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .req_valid  (req_valid),
        .req_addr   (req_addr),
        .req_slot   (req_slot),
        .req_store  (req_store),
        .fill       (fill),
        .status     (status),
        .mshr_full  (mshr_full),
        .fill_valid (fill_valid),
        .fill_resp  (fill_resp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_status(input string name, input req_status_t exp,
                                input req_status_t act);
        if (act !== exp) begin
            fail_run($sformatf("** Error %s: status expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic check_full(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            fail_run($sformatf("** Error %s: mshr_full expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic check_fill(input string name, input fill_resp_t exp, input fill_resp_t act);
        if (act !== exp) begin
            fail_run($sformatf("** Error %s: fill_resp expected %h actual %h", name, exp, act));
        end
    endtask

    function automatic int find_line(input line_addr_t line);
        int idx;
        idx = -1;
        for (int i = 0; i < model_q.size(); i++) begin
            if (model_q[i].line == line) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    // A line that is not outstanding in the model.
    function automatic line_addr_t new_line();
        line_addr_t line;
        line = line_addr_t'($urandom);
        while (find_line(line) >= 0) begin
            line = line_addr_t'($urandom);
        end
        return line;
    endfunction

    function automatic phys_addr_t make_addr(input line_addr_t line);
        logic [LINE_LSB-1:0] offset;
        offset = LINE_LSB'($urandom); // Random byte offset.
        return {line, offset};
    endfunction

    function automatic slot_mask_t one_hot_slot();
        int unsigned pos;
        pos = $urandom % SLOTS;
        return slot_mask_t'(1) << pos;
    endfunction

    task automatic wait_fill(input string name, output int cycles);
        cycles = 0;
        while (!fill_valid) begin
            if (cycles == TIMEOUT) begin
                fail_run($sformatf("%s: no fill response within %0d cycles", name, TIMEOUT));
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic expect_no_fill(input string name);
        for (int i = 0; i < TIMEOUT; i++) begin
            @(negedge clk);
            if (fill_valid) begin
                fail_run($sformatf("%s: fill_valid rose after a fill to an empty table", name));
            end
        end
    endtask

    // Request is sampled one edge before the fill so both meet in one table edge.
    task automatic issue(input string name, input logic do_req, input phys_addr_t addr,
                         input slot_mask_t slot, input logic store, input logic do_fill);
        req_status_t exp_st;
        fill_resp_t  exp_fill;
        fill_resp_t  entry;
        logic        exp_pop;
        line_addr_t  line;
        int          idx;
        int          waited;
        exp_st   = '0;
        exp_fill = '0;
        line     = addr[PADDR_W-1:LINE_LSB];
        exp_pop  = do_fill && (model_q.size() != 0);
        if (exp_pop) begin
            exp_fill = model_q.pop_front(); // Pop goes first.
        end
        if (do_req) begin
            idx = find_line(line);
            if (idx >= 0) begin
                entry = model_q[idx];
                if (store) begin
                    entry.sw_slots = entry.sw_slots | slot;
                end else begin
                    entry.rd_slots = entry.rd_slots | slot;
                end
                model_q[idx] = entry;
                exp_st.hit   = 1'b1;
            end else if (model_q.size() < MSHR_DEPTH) begin
                entry.line     = line;
                entry.rd_slots = store ? '0 : slot;
                entry.sw_slots = store ? slot : '0;
                model_q.push_back(entry);
                exp_st.alloc = 1'b1;
            end else begin
                exp_st.refused = 1'b1;
            end
        end

        req_valid = do_req;
        req_addr  = addr;
        req_slot  = slot;
        req_store = store;
        @(negedge clk);
        req_valid = 1'b0;
        fill      = do_fill;
        @(negedge clk);
        fill = 1'b0;
        check_status(name, exp_st, status);
        check_full(name, model_q.size() == MSHR_DEPTH, mshr_full);
        if (exp_pop) begin
            wait_fill(name, waited);
            if (waited != 1) begin
                fail_run($sformatf("%s: fill response came %0d cycles after the fill, not 2",
                                   name, waited + 1));
            end
            check_fill(name, exp_fill, fill_resp);
        end else if (do_fill) begin
            expect_no_fill(name);
        end
    endtask

    task automatic drain(input string name);
        while (model_q.size() != 0) begin
            issue(name, 1'b0, '0, '0, 1'b0, 1'b1);
        end
    endtask

    task automatic fill_table(input string name);
        while (model_q.size() < MSHR_DEPTH) begin
            issue(name, 1'b1, make_addr(new_line()), one_hot_slot(), 1'($urandom), 1'b0);
        end
    endtask

    task automatic test_alloc();
        fill_table("test_alloc"); // mshr_full checked on every step.
        drain("test_alloc");
    endtask

    task automatic test_merge();
        line_addr_t a;
        line_addr_t b;
        a = new_line();
        issue("test_merge", 1'b1, make_addr(a), one_hot_slot(), 1'b0, 1'b0);
        b = new_line();
        issue("test_merge", 1'b1, make_addr(b), one_hot_slot(), 1'b1, 1'b0);
        for (int i = 0; i < 6; i++) begin
            issue("test_merge", 1'b1, make_addr(a), one_hot_slot(), 1'(i % 2), 1'b0);
            issue("test_merge", 1'b1, make_addr(b), one_hot_slot(), 1'(i / 3), 1'b0);
        end
        drain("test_merge");
    endtask

    task automatic test_refuse();
        fill_table("test_refuse");
        issue("test_refuse", 1'b1, make_addr(new_line()), one_hot_slot(), 1'b0, 1'b0);
        issue("test_refuse", 1'b1, make_addr(new_line()), one_hot_slot(), 1'b1, 1'b0);
        drain("test_refuse");
    endtask

    task automatic test_fill_order();
        for (int i = 0; i < 4; i++) begin
            issue("test_fill_order", 1'b1, make_addr(new_line()), one_hot_slot(),
                  1'($urandom), 1'b0);
        end
        drain("test_fill_order");
        issue("test_fill_order", 1'b0, '0, '0, 1'b0, 1'b1); // Empty table.
    endtask

    task automatic test_same_edge();
        line_addr_t a;
        a = new_line();
        issue("test_same_edge", 1'b1, make_addr(a), one_hot_slot(), 1'b0, 1'b0);
        issue("test_same_edge", 1'b1, make_addr(new_line()), one_hot_slot(), 1'b1, 1'b0);
        issue("test_same_edge", 1'b1, make_addr(a), one_hot_slot(), 1'b0, 1'b1);
        drain("test_same_edge");
        fill_table("test_same_edge");
        issue("test_same_edge", 1'b1, make_addr(new_line()), one_hot_slot(), 1'b1, 1'b1);
        drain("test_same_edge");
    endtask

    task automatic test_random_mix();
        int k;
        for (int i = 0; i < POOL_SIZE; i++) begin
            pool[i] = line_addr_t'($urandom);
        end
        for (int n = 0; n < 200; n++) begin
            k = int'($urandom % POOL_SIZE);
            issue("test_random_mix", 1'b1, make_addr(pool[k]), one_hot_slot(),
                  1'($urandom), ($urandom % 3) == 0);
            if (($urandom % 5) == 0) begin
                issue("test_random_mix", 1'b0, '0, '0, 1'b0, 1'b1);
            end
        end
        drain("test_random_mix");
    endtask

    initial begin
        arst_n    = 1'b1;
        req_valid = 1'b0;
        req_addr  = '0;
        req_slot  = '0;
        req_store = 1'b0;
        fill      = 1'b0;
        void'($urandom(SEED));
        #1 arst_n = 1'b0;
        repeat (16) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        test_alloc();
        test_merge();
        test_refuse();
        test_fill_order();
        test_same_edge();
        test_random_mix();

        if (dut.u_mshr_assert.fail_count != 0) begin
            fail_run($sformatf("%0d assertion failures were reported",
                               dut.u_mshr_assert.fail_count));
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

//--- bench/mshr_assert.sv
module mshr_assert (
    input logic                  clk,
    input logic                  arst_n,
    input logic                  fill,
    input mshr_pkg::req_status_t status,
    input logic                  mshr_full,
    input logic                  fill_valid
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_count = 0; // Read by the testbench at the end.

    // Hit, alloc and refused are mutually exclusive.
    status_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(status))
    else begin
        fail_count++;
        $error("status has more than one bit set");
    end

    // Back to back fill_valid needs fills on back to back edges.
    fill_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        (fill_valid && $past(fill_valid)) |-> $past(fill, 2))
    else begin
        fail_count++;
        $error("fill_valid held for two cycles without a second fill");
    end

    reset_quiet: assert property (@(posedge clk)
        !arst_n |-> ((status == '0) && !mshr_full && !fill_valid))
    else begin
        fail_count++;
        $error("outputs not cleared while arst_n is low");
    end

endmodule

bind mshr_top mshr_assert u_mshr_assert (
    .clk        (clk),
    .arst_n     (arst_n),
    .fill       (fill),
    .status     (status),
    .mshr_full  (mshr_full),
    .fill_valid (fill_valid)
);

//--- logic/mshr_top.sv
module mshr_top (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  req_valid,
    input  mshr_pkg::phys_addr_t  req_addr,
    input  mshr_pkg::slot_mask_t  req_slot,
    input  logic                  req_store,
    input  logic                  fill,
    output mshr_pkg::req_status_t status,
    output logic                  mshr_full,
    output logic                  fill_valid,
    output mshr_pkg::fill_resp_t  fill_resp
);
    import mshr_pkg::*;

    logic       miss_valid;
    miss_req_t  miss_req;
    logic       pop_valid;
    fill_resp_t pop_resp;

    miss_intake u_miss_intake (
        .clk        (clk),
        .arst_n     (arst_n),
        .req_valid  (req_valid),
        .req_addr   (req_addr),
        .req_slot   (req_slot),
        .req_store  (req_store),
        .miss_valid (miss_valid),
        .miss_req   (miss_req)
    );

    mshr_table u_mshr_table (
        .clk        (clk),
        .arst_n     (arst_n),
        .miss_valid (miss_valid),
        .miss_req   (miss_req),
        .fill       (fill),
        .status     (status),
        .mshr_full  (mshr_full),
        .pop_valid  (pop_valid),
        .pop_resp   (pop_resp)
    );

    fill_return u_fill_return (
        .clk        (clk),
        .arst_n     (arst_n),
        .pop_valid  (pop_valid),
        .pop_resp   (pop_resp),
        .fill_valid (fill_valid),
        .fill_resp  (fill_resp)
    );

endmodule

//--- logic/fill_return.sv
module fill_return (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 pop_valid,
    input  mshr_pkg::fill_resp_t pop_resp,
    output logic                 fill_valid,
    output mshr_pkg::fill_resp_t fill_resp
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fill_valid <= 1'b0;
        end else begin
            fill_valid <= pop_valid; // One cycle per pop.
        end
    end

    // Line and both masks go out together and hold until the next fill.
    always_ff @(posedge clk) begin
        if (pop_valid) begin
            fill_resp <= pop_resp;
        end
    end

endmodule

//--- logic/mshr_table.sv
module mshr_table (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  miss_valid,
    input  mshr_pkg::miss_req_t   miss_req,
    input  logic                  fill,
    output mshr_pkg::req_status_t status,
    output logic                  mshr_full,
    output logic                  pop_valid,
    output mshr_pkg::fill_resp_t  pop_resp
);
    import mshr_pkg::*;

    mshr_entry_t entries [MSHR_DEPTH];
    mshr_ptr_t   head;
    mshr_ptr_t   tail;
    mshr_count_t count;

    mshr_entry_t           head_entry;
    logic [MSHR_DEPTH-1:0] match;
    logic                  do_pop;
    logic                  hit;
    logic                  do_alloc;
    logic                  no_space;
    mshr_count_t           count_after;
    slot_mask_t            rd_in;
    slot_mask_t            sw_in;
    req_status_t           status_nxt;

    always_comb begin
        head_entry  = entries[head];
        do_pop      = fill && (count != '0); // Fill on empty table is dropped.
        count_after = count - mshr_count_t'(do_pop);
        no_space    = (count_after == mshr_count_t'(MSHR_DEPTH));

        rd_in = miss_req.is_store ? '0 : miss_req.slot;
        sw_in = miss_req.is_store ? miss_req.slot : '0;

        // Parallel line compare that skips the head leaving on this edge.
        for (int i = 0; i < MSHR_DEPTH; i++) begin
            match[i] = miss_valid && entries[i].valid
                       && (entries[i].line == miss_req.line)
                       && !(do_pop && (mshr_ptr_t'(i) == head));
        end

        hit      = |match;
        do_alloc = miss_valid && !hit && !no_space;

        status_nxt.hit     = hit;
        status_nxt.alloc   = do_alloc;
        status_nxt.refused = miss_valid && !hit && no_space;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            status    <= '0;
            pop_valid <= 1'b0;
        end else begin
            if (do_pop) begin
                head <= head + mshr_ptr_t'(1);
            end
            if (do_alloc) begin
                tail <= tail + mshr_ptr_t'(1);
            end
            count     <= count_after + mshr_count_t'(do_alloc);
            status    <= status_nxt;
            pop_valid <= do_pop;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < MSHR_DEPTH; i++) begin
                entries[i] <= '0;
            end
        end else begin
            if (do_pop) begin
                entries[head].valid <= 1'b0;
            end
            for (int i = 0; i < MSHR_DEPTH; i++) begin
                if (match[i]) begin
                    entries[i].rd_slots <= entries[i].rd_slots | rd_in;
                    entries[i].sw_slots <= entries[i].sw_slots | sw_in;
                end
            end
            // When full, tail equals head, so this overrides the pop clear.
            if (do_alloc) begin
                entries[tail].valid    <= 1'b1;
                entries[tail].line     <= miss_req.line;
                entries[tail].rd_slots <= rd_in;
                entries[tail].sw_slots <= sw_in;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_pop) begin
            pop_resp.line     <= head_entry.line;
            pop_resp.rd_slots <= head_entry.rd_slots;
            pop_resp.sw_slots <= head_entry.sw_slots;
        end
    end

    assign mshr_full = (count == mshr_count_t'(MSHR_DEPTH));

endmodule

//--- logic/miss_intake.sv
module miss_intake (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 req_valid,
    input  mshr_pkg::phys_addr_t req_addr,
    input  mshr_pkg::slot_mask_t req_slot,
    input  logic                 req_store,
    output logic                 miss_valid,
    output mshr_pkg::miss_req_t  miss_req
);
    import mshr_pkg::*;

    line_addr_t req_line;

    // Offset bits within the line are dropped here.
    assign req_line = req_addr[PADDR_W-1:LINE_LSB];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            miss_valid <= 1'b0;
        end else begin
            miss_valid <= req_valid; // One pulse per strobe.
        end
    end

    // Payload only moves on a strobe.
    always_ff @(posedge clk) begin
        if (req_valid) begin
            miss_req.line     <= req_line;
            miss_req.slot     <= req_slot;
            miss_req.is_store <= req_store;
        end
    end

endmodule

//--- logic/mshr_pkg.sv
package mshr_pkg;

    localparam int MSHR_DEPTH = 8;
    localparam int PTR_W      = 3;
    localparam int LINE_LSB   = 4;
    localparam int PADDR_W    = 15;
    localparam int LINE_W     = 11;
    localparam int SLOTS      = 8;

    typedef logic [PADDR_W-1:0] phys_addr_t;
    typedef logic [LINE_W-1:0]  line_addr_t;  // Address bits 14:4.
    typedef logic [SLOTS-1:0]   slot_mask_t;
    typedef logic [PTR_W-1:0]   mshr_ptr_t;
    typedef logic [PTR_W:0]     mshr_count_t; // Holds 0 through MSHR_DEPTH.

    typedef struct packed {
        line_addr_t line;
        slot_mask_t slot;
        logic       is_store;
    } miss_req_t;

    // Valid sits in the top bit of the entry word.
    typedef struct packed {
        logic       valid;
        line_addr_t line;
        slot_mask_t rd_slots;
        slot_mask_t sw_slots;
    } mshr_entry_t;

    typedef struct packed {
        line_addr_t line;
        slot_mask_t rd_slots;
        slot_mask_t sw_slots;
    } fill_resp_t;

    typedef struct packed {
        logic hit;
        logic alloc;
        logic refused;
    } req_status_t;

endpackage
